/* Bender.yml */
package:
  name: dcache

sources:
  - dcache_pkg.sv
  - dcache_data_ram.sv
  - dcache_beat_ctr.sv
  - dcache_lru.sv
  - dcache_tag_store.sv
  - dcache_fsm.sv
  - dcache_top.sv
  - target: simulation
    files:
      - tb_dcache.sv

/* compile.f */
dcache_pkg.sv
dcache_data_ram.sv
dcache_beat_ctr.sv
dcache_lru.sv
dcache_tag_store.sv
dcache_fsm.sv
dcache_top.sv
tb_dcache.sv

/* dcache_beat_ctr.sv */
`timescale 1ns/1ps
`default_nettype none

module dcache_beat_ctr (
    input  wire                                clk,
    input  wire                                rst_n,
    input  wire logic                          beat_start_i,
    input  wire logic                          beat_step_i,
    input  wire logic                          beat_clear_i,
    input  wire logic [dcache_pkg::set_w-1:0]  set_i,
    input  wire logic [dcache_pkg::row_w-1:0]  req_row_i,
    output logic                               beat_last_o,
    output logic [dcache_pkg::row_w-1:0]       row_o
);
    import dcache_pkg::*;

    logic             active_q;
    logic             last_q;
    logic [row_w-1:0] row_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            active_q <= 1'b0;
            last_q   <= 1'b0;
            row_q    <= '0;
        end else if (beat_start_i) begin
            active_q <= 1'b1;
            last_q   <= 1'b0;
            row_q    <= {set_i, 1'b0};
        end else if (beat_clear_i) begin
            // back to half 0 of the same set
            active_q <= 1'b0;
            last_q   <= 1'b0;
            row_q    <= {row_q[row_w-1:1], 1'b0};
        end else if (beat_step_i) begin
            last_q <= ~last_q;
            row_q  <= row_q + 1'b1;
        end
    end

    assign beat_last_o = last_q;
    // outside a burst the array follows the request row
    assign row_o = active_q ? row_q : req_row_i;

endmodule

`default_nettype wire

/* dcache_data_ram.sv */
`timescale 1ns/1ps
`default_nettype none

module dcache_data_ram (
    input  wire                                              clk,
    input  wire logic                                        ren_i,
    input  wire logic [dcache_pkg::num_ways-1:0]             wen_i,
    input  wire logic [dcache_pkg::row_w-1:0]                row_i,
    input  wire dcache_pkg::half_line_u                      wdata_i,
    output dcache_pkg::half_line_u [dcache_pkg::num_ways-1:0] rdata_o
);
    import dcache_pkg::*;

    half_line_u mem [num_ways][2**row_w];

    // one registered read port per way, held while ren_i is low
    always_ff @(posedge clk) begin
        for (int w = 0; w < num_ways; w++) begin
            if (wen_i[w]) begin
                mem[w][row_i] <= wdata_i;
            end
            if (ren_i) begin
                rdata_o[w] <= mem[w][row_i];
            end
        end
    end

endmodule

`default_nettype wire

/* dcache_fsm.sv */
`timescale 1ns/1ps
`default_nettype none

module dcache_fsm (
    input  wire                                     clk,
    input  wire                                     rst_n,
    // core side
    input  wire logic                               fetch_req_i,
    input  wire logic                               fetch_we_i,
    input  wire logic [dcache_pkg::addr_w-1:0]      fetch_addr_i,
    input  wire logic [dcache_pkg::data_w-1:0]      fetch_w_data_i,
    output logic                                    fetch_gnt_o,
    output logic [dcache_pkg::data_w-1:0]           fetch_r_data_o,
    output logic                                    fetch_r_valid_o,
    // line buffer side
    output logic                                    refill_req_o,
    output logic                                    refill_we_o,
    output logic [dcache_pkg::line_addr_w-1:0]      refill_addr_o,
    output logic                                    refill_addr_valid_o,
    output logic                                    refill_wvalid_o,
    output logic [dcache_pkg::half_bits-1:0]        refill_wdata_o,
    input  wire logic                               refill_gnt_i,
    input  wire logic                               refill_addr_ready_i,
    input  wire logic                               refill_rvalid_i,
    input  wire logic [dcache_pkg::half_bits-1:0]   refill_rdata_i,
    // internal
    output logic                                    beat_start_o,
    output logic                                    beat_step_o,
    output logic                                    beat_clear_o,
    input  wire logic                               beat_last_i,
    output logic [dcache_pkg::row_w-1:0]            req_row_o,
    output logic                                    tag_rd_o,
    output logic                                    line_fill_o,
    output logic                                    mark_dirty_o,
    output logic [dcache_pkg::set_w-1:0]            set_o,
    output logic [dcache_pkg::tag_w-1:0]            tag_o,
    output logic [dcache_pkg::num_ways-1:0]         fill_way_o,
    input  wire logic [dcache_pkg::num_ways-1:0]    hit_way_i,
    input  wire logic                               victim_dirty_i,
    input  wire logic [dcache_pkg::tag_w-1:0]       victim_tag_i,
    input  wire logic [dcache_pkg::num_ways-1:0]    victim_way_i,
    output logic                                    touch_o,
    output logic [dcache_pkg::num_ways-1:0]         touch_way_o,
    output logic                                    ram_ren_o,
    output logic [dcache_pkg::num_ways-1:0]         ram_wen_o,
    output dcache_pkg::half_line_u                  ram_wdata_o,
    input  wire dcache_pkg::half_line_u [dcache_pkg::num_ways-1:0] ram_rdata_i
);
    import dcache_pkg::*;

    dcache_state_e         state_q, state_d;
    logic [addr_w-1:0]     addr_q;
    logic [data_w-1:0]     wdata_q;
    logic                  we_q;
    logic [num_ways-1:0]   victim_q;
    logic                  ahalf_q, ahalf_d;
    logic                  adone_q, adone_d;
    logic                  staged_q, staged_d;
    logic                  hit;
    logic                  half;
    logic [word_sel_w-1:0] word;
    half_line_u            src_line, wr_line, victim_line;

    assign hit    = |hit_way_i;
    assign tag_o  = addr_q[addr_w-1 -: tag_w];
    assign set_o  = addr_q[addr_w-tag_w-1 -: set_w];
    assign half   = addr_q[word_sel_w+2];
    assign word   = addr_q[word_sel_w+1 -: word_sel_w];
    assign fill_way_o = victim_q;
    assign tag_rd_o   = fetch_gnt_o;
    assign ram_wdata_o = wr_line;
    // a write hit uses the registered row, a new request its own
    assign req_row_o = fetch_gnt_o ? fetch_addr_i[addr_w-tag_w-1 -: row_w]
                                   : addr_q[addr_w-tag_w-1 -: row_w];

    always_comb begin
        src_line    = hit_way_i[1] ? ram_rdata_i[1] : ram_rdata_i[0];
        victim_line = victim_q[1] ? ram_rdata_i[1] : ram_rdata_i[0];
        if (state_q == st_refill) begin
            src_line.raw = refill_rdata_i;
        end
        wr_line = src_line;
        if (we_q && (state_q != st_refill || beat_last_i == half)) begin
            wr_line.words[word] = wdata_q;
        end
    end

    always_comb begin
        state_d  = state_q;
        ahalf_d  = ahalf_q;
        adone_d  = adone_q;
        staged_d = staged_q;
        fetch_gnt_o         = 1'b0;
        fetch_r_valid_o     = 1'b0;
        fetch_r_data_o      = src_line.words[word];
        refill_req_o        = 1'b0;
        refill_we_o         = 1'b0;
        refill_addr_o       = {tag_o, set_o, ahalf_q};
        refill_addr_valid_o = 1'b0;
        refill_wvalid_o     = 1'b0;
        refill_wdata_o      = victim_line.raw;
        beat_start_o = 1'b0;
        beat_step_o  = 1'b0;
        beat_clear_o = 1'b0;
        line_fill_o  = 1'b0;
        mark_dirty_o = 1'b0;
        touch_o      = 1'b0;
        touch_way_o  = hit_way_i;
        ram_ren_o    = 1'b0;
        ram_wen_o    = '0;

        case (state_q)
            st_idle: begin
                if (fetch_req_i) begin
                    fetch_gnt_o = 1'b1;
                    ram_ren_o   = 1'b1;
                    state_d     = st_compare;
                end
            end
            st_compare: begin
                if (hit) begin
                    touch_o = 1'b1;
                    if (we_q) begin
                        ram_wen_o    = hit_way_i;
                        mark_dirty_o = 1'b1;
                        state_d      = st_idle;
                    end else begin
                        fetch_r_valid_o = 1'b1;
                        // next request overlaps this answer
                        if (fetch_req_i) begin
                            fetch_gnt_o = 1'b1;
                            ram_ren_o   = 1'b1;
                        end else begin
                            state_d = st_idle;
                        end
                    end
                end else begin
                    refill_req_o = 1'b1;
                    refill_we_o  = victim_dirty_i;
                    if (refill_gnt_i) begin
                        beat_start_o = 1'b1;
                        state_d = victim_dirty_i ? st_store : st_refill;
                    end else begin
                        state_d = victim_dirty_i ? st_store_req : st_refill_req;
                    end
                end
            end
            st_store_req, st_refill_req: begin
                refill_req_o = 1'b1;
                refill_we_o  = (state_q == st_store_req);
                if (refill_gnt_i) begin
                    beat_start_o = 1'b1;
                    state_d = (state_q == st_store_req) ? st_store : st_refill;
                end
            end
            st_store: begin
                // read the victim half first, then offer it
                if (!staged_q) begin
                    ram_ren_o = 1'b1;
                    staged_d  = 1'b1;
                end else begin
                    refill_addr_valid_o = 1'b1;
                    refill_wvalid_o     = 1'b1;
                    refill_addr_o       = {victim_tag_i, set_o, beat_last_i};
                    if (refill_addr_ready_i) begin
                        staged_d = 1'b0;
                        if (beat_last_i) begin
                            beat_clear_o = 1'b1;
                            state_d      = st_refill_req;
                        end else begin
                            beat_step_o = 1'b1;
                        end
                    end
                end
            end
            st_refill: begin
                if (!adone_q) begin
                    refill_addr_valid_o = 1'b1;
                    if (refill_addr_ready_i) begin
                        ahalf_d = ~ahalf_q;
                        adone_d = ahalf_q;
                    end
                end
                if (refill_rvalid_i) begin
                    ram_wen_o = victim_q;
                    if (!we_q && beat_last_i == half) begin
                        fetch_r_valid_o = 1'b1;
                    end
                    if (beat_last_i) begin
                        beat_clear_o = 1'b1;
                        line_fill_o  = 1'b1;
                        mark_dirty_o = we_q;
                        touch_o      = 1'b1;
                        touch_way_o  = victim_q;
                        adone_d      = 1'b0;
                        state_d      = st_idle;
                    end else begin
                        beat_step_o = 1'b1;
                    end
                end
            end
            default: state_d = st_idle;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q  <= st_idle;
            we_q     <= 1'b0;
            victim_q <= '0;
            ahalf_q  <= 1'b0;
            adone_q  <= 1'b0;
            staged_q <= 1'b0;
        end else begin
            state_q  <= state_d;
            ahalf_q  <= ahalf_d;
            adone_q  <= adone_d;
            staged_q <= staged_d;
            if (fetch_gnt_o) begin
                we_q <= fetch_we_i;
            end
            if (state_q == st_compare && !hit) begin
                victim_q <= victim_way_i;
            end
        end
    end

    // request payload
    always_ff @(posedge clk) begin
        if (fetch_gnt_o) begin
            addr_q  <= fetch_addr_i;
            wdata_q <= fetch_w_data_i;
        end
    end

endmodule

`default_nettype wire

/* dcache_lru.sv */
`timescale 1ns/1ps
`default_nettype none

module dcache_lru (
    input  wire                                  clk,
    input  wire                                  rst_n,
    input  wire logic [dcache_pkg::set_w-1:0]    set_i,
    input  wire logic [dcache_pkg::num_ways-1:0] valid_i,
    input  wire logic                            touch_i,
    input  wire logic [dcache_pkg::num_ways-1:0] touch_way_i,
    output logic [dcache_pkg::num_ways-1:0]      victim_way_o
);
    import dcache_pkg::*;

    // set bit means way 1 is the older one
    logic [num_sets-1:0] lru_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lru_q <= '0;
        end else if (touch_i) begin
            lru_q[set_i] <= touch_way_i[0];
        end
    end

    always_comb begin
        victim_way_o = '0;
        if (!valid_i[0]) begin
            victim_way_o[0] = 1'b1;
        end else if (!valid_i[1]) begin
            victim_way_o[1] = 1'b1;
        end else begin
            victim_way_o[lru_q[set_i]] = 1'b1;
        end
    end

endmodule

`default_nettype wire

/* dcache_pkg.sv */
`default_nettype none

package dcache_pkg;

    // cache geometry
    localparam int num_ways    = 2;
    localparam int num_sets    = 8;
    localparam int tag_w       = 8;
    localparam int set_w       = 3;
    localparam int word_sel_w  = 3;
    localparam int line_addr_w = 12;
    localparam int row_w       = 4;
    localparam int half_bits   = 256;
    localparam int data_w      = 32;
    localparam int addr_w      = 17;

    typedef enum logic [2:0] {
        st_idle,
        st_compare,
        st_store_req,
        st_refill_req,
        st_store,
        st_refill
    } dcache_state_e;

    // raw for the LB side, words for extract and merge
    typedef union packed {
        logic [half_bits-1:0]                         raw;
        logic [half_bits/data_w-1:0][data_w-1:0]      words;
    } half_line_u;

endpackage

`default_nettype wire

/* dcache_stimulus.txt */
# columns are op (R read, W write), address, write data, expected read data
# all values hex, expected data is not used for writes
# cold miss on tag 01 in set 2
R 002ac 00000000 100000ab
# hit on the same word
R 002ac 00000000 100000ab
# write hit then the word and its neighbour
W 002ac deadbeef 00000000
R 002ac 00000000 deadbeef
R 002a8 00000000 100000aa
# tag 02 fills way 1 and tag 03 evicts the dirty line
R 00480 00000000 10000120
R 006b4 00000000 100001ad
# evicted line comes back from the line buffer
R 002ac 00000000 deadbeef
R 00280 00000000 100000a0

/* dcache_tag_store.sv */
`timescale 1ns/1ps
`default_nettype none

module dcache_tag_store (
    input  wire                                  clk,
    input  wire                                  rst_n,
    input  wire logic [dcache_pkg::set_w-1:0]    set_i,
    input  wire logic [dcache_pkg::set_w-1:0]    rd_set_i,
    input  wire logic [dcache_pkg::tag_w-1:0]    tag_i,
    input  wire logic                            tag_rd_i,
    input  wire logic                            line_fill_i,
    input  wire logic [dcache_pkg::num_ways-1:0] fill_way_i,
    input  wire logic                            mark_dirty_i,
    output logic [dcache_pkg::num_ways-1:0]      hit_way_o,
    output logic [dcache_pkg::num_ways-1:0]      valid_o,
    input  wire logic [dcache_pkg::num_ways-1:0] victim_way_i,
    output logic                                 victim_dirty_o,
    output logic [dcache_pkg::tag_w-1:0]         victim_tag_o
);
    import dcache_pkg::*;

    logic [tag_w-1:0]                   tags [num_sets][num_ways];
    logic [num_ways-1:0][tag_w-1:0]     tag_q;
    logic [num_sets-1:0][num_ways-1:0]  valid_q;
    logic [num_sets-1:0][num_ways-1:0]  dirty_q;

    // tags read at request time, written when a refill ends
    always_ff @(posedge clk) begin
        for (int w = 0; w < num_ways; w++) begin
            if (line_fill_i && fill_way_i[w]) begin
                tags[set_i][w] <= tag_i;
            end
            if (tag_rd_i) begin
                tag_q[w] <= tags[rd_set_i][w];
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else if (line_fill_i) begin
            valid_q[set_i] <= valid_q[set_i] | fill_way_i;
            // a write miss leaves the new line dirty
            if (mark_dirty_i) begin
                dirty_q[set_i] <= dirty_q[set_i] | fill_way_i;
            end else begin
                dirty_q[set_i] <= dirty_q[set_i] & ~fill_way_i;
            end
        end else if (mark_dirty_i) begin
            dirty_q[set_i] <= dirty_q[set_i] | hit_way_o;
        end
    end

    always_comb begin
        victim_tag_o = tag_q[0];
        for (int w = 0; w < num_ways; w++) begin
            hit_way_o[w] = valid_q[set_i][w] && (tag_q[w] == tag_i);
            if (victim_way_i[w]) begin
                victim_tag_o = tag_q[w];
            end
        end
    end

    assign valid_o        = valid_q[set_i];
    assign victim_dirty_o = |(dirty_q[set_i] & victim_way_i);

endmodule

`default_nettype wire

/* dcache_top.sv */
`timescale 1ns/1ps
`default_nettype none

module dcache_top (
    input  wire                                    clk,
    input  wire                                    rst_n,
    input  wire logic                              fetch_req_i,
    input  wire logic                              fetch_we_i,
    input  wire logic [dcache_pkg::addr_w-1:0]     fetch_addr_i,
    input  wire logic [dcache_pkg::data_w-1:0]     fetch_w_data_i,
    output logic                                   fetch_gnt_o,
    output logic [dcache_pkg::data_w-1:0]          fetch_r_data_o,
    output logic                                   fetch_r_valid_o,
    output logic                                   refill_req_o,
    output logic                                   refill_we_o,
    output logic [dcache_pkg::line_addr_w-1:0]     refill_addr_o,
    output logic                                   refill_addr_valid_o,
    output logic                                   refill_wvalid_o,
    output logic [dcache_pkg::half_bits-1:0]       refill_wdata_o,
    input  wire logic                              refill_gnt_i,
    input  wire logic                              refill_addr_ready_i,
    input  wire logic                              refill_rvalid_i,
    input  wire logic [dcache_pkg::half_bits-1:0]  refill_rdata_i
);
    import dcache_pkg::*;

    logic beat_start, beat_step, beat_clear, beat_last;
    logic tag_rd, line_fill, mark_dirty, touch, ram_ren, victim_dirty;
    logic [row_w-1:0]    row, req_row;
    logic [set_w-1:0]    set;
    logic [tag_w-1:0]    tag, victim_tag;
    logic [num_ways-1:0] fill_way, hit_way, victim_way, touch_way, ram_wen, valid;
    half_line_u                  ram_wdata;
    half_line_u [num_ways-1:0]   ram_rdata;

    dcache_fsm u_fsm (
        .clk, .rst_n,
        .fetch_req_i, .fetch_we_i, .fetch_addr_i, .fetch_w_data_i,
        .fetch_gnt_o, .fetch_r_data_o, .fetch_r_valid_o,
        .refill_req_o, .refill_we_o, .refill_addr_o, .refill_addr_valid_o,
        .refill_wvalid_o, .refill_wdata_o, .refill_gnt_i, .refill_addr_ready_i,
        .refill_rvalid_i, .refill_rdata_i,
        .beat_start_o(beat_start), .beat_step_o(beat_step), .beat_clear_o(beat_clear),
        .beat_last_i(beat_last), .req_row_o(req_row), .tag_rd_o(tag_rd),
        .line_fill_o(line_fill), .mark_dirty_o(mark_dirty), .set_o(set), .tag_o(tag),
        .fill_way_o(fill_way), .hit_way_i(hit_way), .victim_dirty_i(victim_dirty),
        .victim_tag_i(victim_tag), .victim_way_i(victim_way), .touch_o(touch),
        .touch_way_o(touch_way), .ram_ren_o(ram_ren), .ram_wen_o(ram_wen),
        .ram_wdata_o(ram_wdata), .ram_rdata_i(ram_rdata)
    );

    dcache_beat_ctr u_beat_ctr (
        .clk, .rst_n,
        .beat_start_i(beat_start), .beat_step_i(beat_step), .beat_clear_i(beat_clear),
        .set_i(set), .req_row_i(req_row), .beat_last_o(beat_last), .row_o(row)
    );

    dcache_tag_store u_tag_store (
        .clk, .rst_n,
        .set_i(set), .rd_set_i(req_row[row_w-1:1]), .tag_i(tag), .tag_rd_i(tag_rd),
        .line_fill_i(line_fill), .fill_way_i(fill_way), .mark_dirty_i(mark_dirty),
        .hit_way_o(hit_way), .valid_o(valid), .victim_way_i(victim_way),
        .victim_dirty_o(victim_dirty), .victim_tag_o(victim_tag)
    );

    dcache_lru u_lru (
        .clk, .rst_n,
        .set_i(set), .valid_i(valid), .touch_i(touch), .touch_way_i(touch_way),
        .victim_way_o(victim_way)
    );

    dcache_data_ram u_data_ram (
        .clk,
        .ren_i(ram_ren), .wen_i(ram_wen), .row_i(row), .wdata_i(ram_wdata),
        .rdata_o(ram_rdata)
    );

endmodule

`default_nettype wire

/* tb_dcache.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_dcache;
    import dcache_pkg::*;

    localparam int cycles_per_op = 400;
    localparam int reset_cycles  = 10;
    // byte and word offset bits below the half-line select
    localparam int offset_w      = word_sel_w + 2;
    localparam int min_ops       = 9;

    logic                   clk;
    logic                   rst_n;
    logic                   fetch_req_i;
    logic                   fetch_we_i;
    logic [addr_w-1:0]      fetch_addr_i;
    logic [data_w-1:0]      fetch_w_data_i;
    logic                   fetch_gnt_o;
    logic [data_w-1:0]      fetch_r_data_o;
    logic                   fetch_r_valid_o;
    logic                   refill_req_o;
    logic                   refill_we_o;
    logic [line_addr_w-1:0] refill_addr_o;
    logic                   refill_addr_valid_o;
    logic                   refill_wvalid_o;
    logic [half_bits-1:0]   refill_wdata_o;
    logic                   refill_gnt_i;
    logic                   refill_addr_ready_i;
    logic                   refill_rvalid_i;
    logic [half_bits-1:0]   refill_rdata_i;

    // one entry per stimulus line
    byte                    op_q[$];
    logic [addr_w-1:0]      addr_q[$];
    logic [data_w-1:0]      wdata_q[$];
    logic [data_w-1:0]      expect_q[$];

    // line buffer memory and what the cache sent to it
    logic [half_bits-1:0]   lb_mem [2**line_addr_w];
    logic [line_addr_w-1:0] rd_pending[$];
    logic [line_addr_w-1:0] wb_addr_log[$];
    logic [half_bits-1:0]   wb_data_log[$];
    // direction announced at the last LB grant
    logic                   lb_write_grant = 1'b0;

    // expected memory contents as the core sees them
    logic [data_w-1:0]      ref_mem [2**(addr_w-2)];

    int errors        = 0;
    int checks        = 0;
    int tests_run     = 0;
    int lb_req_cycles = 0;
    int read_latency  = 0;
    int cycle_count   = 0;
    int cycle_limit   = 100000;

    dcache_top dut_i (
        .clk, .rst_n,
        .fetch_req_i, .fetch_we_i, .fetch_addr_i, .fetch_w_data_i,
        .fetch_gnt_o, .fetch_r_data_o, .fetch_r_valid_o,
        .refill_req_o, .refill_we_o, .refill_addr_o, .refill_addr_valid_o,
        .refill_wvalid_o, .refill_wdata_o, .refill_gnt_i, .refill_addr_ready_i,
        .refill_rvalid_i, .refill_rdata_i
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        while (cycle_count <= cycle_limit) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("run stopped after %0d cycles without the tests finishing", cycle_limit);
        $display("TEST FAILED");
        $finish;
    end

    function automatic logic [half_bits-1:0] ref_half(input logic [line_addr_w-1:0] la);
        logic [half_bits-1:0] h;
        for (int k = 0; k < half_bits / data_w; k++) begin
            h[k*data_w +: data_w] = ref_mem[la * 8 + k];
        end
        return h;
    endfunction

    task automatic check_true(input string what, input logic cond);
        checks++;
        assert (cond === 1'b1) else begin
            $display("Error at %0d ns: %s", $time, what);
            errors++;
        end
    endtask

    task automatic check_word(input string what, input logic [data_w-1:0] got,
                              input logic [data_w-1:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("Error at %0d ns: %s returned %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic report_test(input int num, input string name, input int first_err);
        tests_run++;
        $display("test %0d, %s: %0d errors", num, name, errors - first_err);
    endtask

    // LB side, sampled where the transfer happens
    always @(posedge clk) begin
        if (refill_req_o) begin
            lb_req_cycles++;
            if (refill_gnt_i) begin
                lb_write_grant = refill_we_o;
            end
        end
        if (refill_addr_valid_o && refill_addr_ready_i) begin
            checks++;
            assert (refill_wvalid_o === lb_write_grant) else begin
                $display("Error at %0d ns: LB transfer at %h does not match refill_we_o",
                         $time, refill_addr_o);
                errors++;
            end
            if (refill_wvalid_o) begin
                checks++;
                assert (refill_wdata_o === ref_half(refill_addr_o)) else begin
                    $display("Error at %0d ns: write-back data for LB address %h is wrong",
                             $time, refill_addr_o);
                    errors++;
                end
                lb_mem[refill_addr_o] = refill_wdata_o;
                wb_addr_log.push_back(refill_addr_o);
                wb_data_log.push_back(refill_wdata_o);
            end else begin
                rd_pending.push_back(refill_addr_o);
            end
        end
    end

    // LB responses with random grant delay and back-pressure
    initial begin
        int unsigned seed;
        seed = 32'h2d91;
        void'($urandom(seed));
        refill_gnt_i        = 1'b0;
        refill_addr_ready_i = 1'b0;
        refill_rvalid_i     = 1'b0;
        refill_rdata_i      = '0;
        for (int la = 0; la < 2**line_addr_w; la++) begin
            for (int k = 0; k < half_bits / data_w; k++) begin
                lb_mem[la][k*data_w +: data_w] = 32'h1000_0000 + la * 8 + k;
            end
        end
        forever begin
            @(negedge clk);
            refill_gnt_i        = refill_req_o && ($urandom % 3 == 0);
            refill_addr_ready_i = ($urandom % 4) != 0;
            if (rd_pending.size() > 0 && ($urandom % 2) == 0) begin
                refill_rvalid_i = 1'b1;
                refill_rdata_i  = lb_mem[rd_pending.pop_front()];
            end else begin
                refill_rvalid_i = 1'b0;
            end
        end
    end

    task automatic load_stimulus(output bit ok);
        int                fd;
        int                n;
        string             line;
        byte               op;
        logic [addr_w-1:0] a;
        logic [data_w-1:0] wd;
        logic [data_w-1:0] ex;
        ok = 1'b0;
        fd = $fopen("dcache_stimulus.txt", "r");
        if (fd != 0) begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                n = $sscanf(line, " %c %h %h %h", op, a, wd, ex);
                // comment lines start with #
                if (n == 4 && (op == "R" || op == "W")) begin
                    op_q.push_back(op);
                    addr_q.push_back(a);
                    wdata_q.push_back(wd);
                    expect_q.push_back(ex);
                end
            end
            $fclose(fd);
            ok = (op_q.size() >= min_ops);
        end
    endtask

    task automatic apply_reset();
        int first_err;
        first_err = errors;
        rst_n = 1'b0;
        repeat (reset_cycles) begin
            @(negedge clk);
            check_true("a strobe output is high while rst_n is low",
                       !(fetch_gnt_o | fetch_r_valid_o | refill_req_o
                         | refill_addr_valid_o | refill_wvalid_o));
        end
        rst_n = 1'b1;
        report_test(6, "strobes low during reset", first_err);
    endtask

    // one core request, read data checked against the file
    task automatic run_op(input int idx);
        logic we;
        we = (op_q[idx] == "W");
        @(negedge clk);
        fetch_req_i    = 1'b1;
        fetch_we_i     = we;
        fetch_addr_i   = addr_q[idx];
        fetch_w_data_i = wdata_q[idx];
        @(posedge clk);
        while (!fetch_gnt_o) begin
            @(posedge clk);
        end
        if (we) begin
            ref_mem[addr_q[idx] >> 2] = wdata_q[idx];
        end
        @(negedge clk);
        fetch_req_i  = 1'b0;
        fetch_we_i   = 1'b0;
        read_latency = 0;
        if (!we) begin
            read_latency = 1;
            @(posedge clk);
            while (!fetch_r_valid_o) begin
                read_latency++;
                @(posedge clk);
            end
            check_word($sformatf("read of %h", addr_q[idx]), fetch_r_data_o, expect_q[idx]);
        end
    endtask

    task automatic run_tests();
        int                     first_err;
        int                     req_before;
        int                     wb_before;
        logic [line_addr_w-2:0] dirty_line;
        logic                   dirty_half;
        logic [word_sel_w-1:0]  dirty_word;

        first_err = errors;
        run_op(0);
        report_test(1, "cold miss refill", first_err);

        first_err  = errors;
        req_before = lb_req_cycles;
        run_op(1);
        check_true("read hit raised refill_req_o", lb_req_cycles == req_before);
        check_true("read hit answered later than one cycle after the grant",
                   read_latency == 1);
        report_test(2, "read hit", first_err);

        first_err = errors;
        run_op(2);
        run_op(3);
        run_op(4);
        report_test(3, "write hit and neighbour", first_err);

        // the dirty line is the one written in test 3
        first_err  = errors;
        wb_before  = wb_addr_log.size();
        dirty_line = addr_q[2][addr_w-1:offset_w+1];
        dirty_half = addr_q[2][offset_w];
        dirty_word = addr_q[2][offset_w-1:2];
        run_op(5);
        check_true("filling the free way wrote a line back", wb_addr_log.size() == wb_before);
        run_op(6);
        check_true("evicting the dirty line did not give two write-back beats",
                   wb_addr_log.size() == wb_before + 2);
        if (wb_addr_log.size() == wb_before + 2) begin
            check_true("write-back beats carry the wrong LB addresses",
                       wb_addr_log[wb_before] == {dirty_line, 1'b0}
                       && wb_addr_log[wb_before+1] == {dirty_line, 1'b1});
            check_word("written word in the write-back data",
                       wb_data_log[wb_before+dirty_half][dirty_word*data_w +: data_w],
                       wdata_q[2]);
        end
        report_test(4, "LRU eviction with write-back", first_err);

        first_err  = errors;
        req_before = lb_req_cycles;
        run_op(7);
        check_true("re-read of the evicted line did not refill", lb_req_cycles > req_before);
        for (int i = min_ops - 1; i < op_q.size(); i++) begin
            run_op(i);
        end
        report_test(5, "evicted line read back", first_err);
    endtask

    initial begin
        bit loaded;
        rst_n          = 1'b0;
        fetch_req_i    = 1'b0;
        fetch_we_i     = 1'b0;
        fetch_addr_i   = '0;
        fetch_w_data_i = '0;
        for (int i = 0; i < 2**(addr_w-2); i++) begin
            ref_mem[i] = 32'h1000_0000 + i;
        end
        load_stimulus(loaded);
        if (!loaded) begin
            $display("dcache_stimulus.txt could not be read or holds too few operations");
            $display("TEST FAILED");
        end else begin
            cycle_limit = cycles_per_op * op_q.size() + 2 * reset_cycles;
            apply_reset();
            run_tests();
            $display("%0d tests, %0d checks, %0d errors, %0d write-back beats",
                     tests_run, checks, errors, wb_addr_log.size());
            if (errors == 0) begin
                $display("TEST PASSED");
            end else begin
                $display("TEST FAILED");
            end
        end
        $finish;
    end

endmodule

`default_nettype wire
